// ==== include/bus_macros.svh ====
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// core side widths
`define ADDR_W 32
`define DATA_W 32

// memory bus is twice the core word
`define AXI_DATA_W 64

// mtime word addresses, served without the bus
`define MTIME_LO_ADDR 32'h0200_BFF8
`define MTIME_HI_ADDR 32'h0200_BFFC

`endif

// ==== src/axi_pkg.sv ====
package axi_pkg;

  // AxSIZE, bytes per beat as a power of two
  typedef enum logic [2:0] {
    SIZE_1B = 3'b000,
    SIZE_2B = 3'b001,
    SIZE_4B = 3'b010
  } axi_size_e;

  // xRESP codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

endpackage

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

  // width of one core access
  typedef enum logic [1:0] {
    WIDTH_B = 2'd0,
    WIDTH_H = 2'd1,
    WIDTH_W = 2'd2
  } access_width_e;

  // bus ownership sequence
  typedef enum logic [2:0] {
    ARB_IF_ADDR  = 3'd0, // idle, fetch address phase
    ARB_IF_DATA  = 3'd1,
    ARB_LS_ADDR  = 3'd2,
    ARB_LS_READ  = 3'd3, // bus or timer read data
    ARB_LS_WRITE = 3'd4
  } arb_state_e;

endpackage

// ==== src/clint.sv ====
`timescale 1ns/1ps
`include "bus_macros.svh"

module clint (
  input  logic               clk,
  input  logic               rst,
  input  logic               rd_en_i,
  input  logic [`ADDR_W-1:0] rd_addr_i,
  output logic [`DATA_W-1:0] rd_data_o,
  output logic               rd_valid_o
);

  logic [63:0] mtime_q;
  logic        hi_sel;

  // bit 2 picks the upper word of mtime
  assign hi_sel = rd_addr_i[2];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q    <= '0;
      rd_valid_o <= 1'b0;
    end
    else
    begin
      mtime_q    <= mtime_q + 64'd1; // free running
      rd_valid_o <= rd_en_i;
    end
  end

  // sampled along with the request
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      if (hi_sel)
        rd_data_o <= mtime_q[63:32];
      else
        rd_data_o <= mtime_q[31:0];
    end
  end

endmodule

// ==== src/lane_align.sv ====
`timescale 1ns/1ps
`include "bus_macros.svh"

module lane_align (
  input  logic [`ADDR_W-1:0]     rd_addr_i,
  input  logic [7:0]             rd_strb_i,
  input  logic [`ADDR_W-1:0]     wr_addr_i,
  input  logic [`DATA_W-1:0]     wr_data_i,
  input  logic [7:0]             wr_strb_i,
  input  logic [`AXI_DATA_W-1:0] axi_rdata_i,
  output axi_pkg::axi_size_e     ar_size_o,
  output axi_pkg::axi_size_e     aw_size_o,
  output logic [`AXI_DATA_W-1:0] axi_wdata_o,
  output logic [7:0]             axi_wstrb_o,
  output logic [`DATA_W-1:0]     rd_word_o
);

  import axi_pkg::*;
  import lsu_pkg::*;

  logic [`DATA_W-1:0] wr_shifted;
  logic [3:0]         wr_nibble;

  // core strobes sit unshifted in the low bits
  function automatic access_width_e strb_to_width(input logic [7:0] strb);
    access_width_e width;
    case (strb)
      8'h01:   width = WIDTH_B;
      8'h03:   width = WIDTH_H;
      8'h0f:   width = WIDTH_W;
      default: width = WIDTH_B;
    endcase
    return width;
  endfunction

  function automatic axi_size_e width_to_size(input access_width_e width);
    axi_size_e size;
    case (width)
      WIDTH_H: size = SIZE_2B;
      WIDTH_W: size = SIZE_4B;
      default: size = SIZE_1B;
    endcase
    return size;
  endfunction

  assign ar_size_o = width_to_size(strb_to_width(rd_strb_i));
  assign aw_size_o = width_to_size(strb_to_width(wr_strb_i));

  // byte offset within the word
  assign wr_shifted = wr_data_i << {wr_addr_i[1:0], 3'b000};
  assign wr_nibble  = wr_strb_i[3:0] << wr_addr_i[1:0];

  // same data on both halves, strobes pick the half
  assign axi_wdata_o = {wr_shifted, wr_shifted};

  always_comb
  begin
    if (wr_addr_i[2])
      axi_wstrb_o = {wr_nibble, 4'b0000};
    else
      axi_wstrb_o = {4'b0000, wr_nibble};
  end

  // whole aligned word, core extracts bytes
  assign rd_word_o = rd_addr_i[2] ? axi_rdata_i[63:32] : axi_rdata_i[31:0];

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps
`include "bus_macros.svh"

module bus_arbiter (
  input  logic               clk,
  input  logic               rst,

  // fetch port
  input  logic               ifu_arvalid_i,
  input  logic [`ADDR_W-1:0] ifu_araddr_i,

  // load/store port
  input  logic               lsu_arvalid_i,
  input  logic [`ADDR_W-1:0] lsu_araddr_i,
  input  logic               lsu_awvalid_i,
  input  logic               lsu_wvalid_i,

  // mtime read
  output logic               timer_rd_en_o,
  input  logic               timer_rd_valid_i,

  // AXI handshakes
  output logic               axi_arvalid_o,
  input  logic               axi_arready_i,
  output logic [`ADDR_W-1:0] axi_araddr_o,
  input  logic               axi_rvalid_i,
  output logic               axi_awvalid_o,
  input  logic               axi_awready_i,
  output logic               axi_wvalid_o,
  input  logic               axi_wready_i,
  input  logic               axi_bvalid_i,

  // completions
  output logic               ifu_rvalid_o,
  output logic               lsu_rvalid_o,
  output logic               lsu_wready_o,
  output logic               rd_is_timer_o
);

  import lsu_pkg::*;

  arb_state_e state_q;
  logic       if_hold_q; // fetch ar is up and waiting for arready
  logic       aw_done_q;
  logic       w_done_q;
  logic       lsu_req;
  logic       timer_hit;
  logic       ls_owns_rd;

  assign lsu_req = lsu_arvalid_i | lsu_awvalid_i;

  // only place the timer range is decoded
  assign timer_hit = lsu_arvalid_i &
                     ((lsu_araddr_i == `MTIME_LO_ADDR) | (lsu_araddr_i == `MTIME_HI_ADDR));

  assign ls_owns_rd   = (state_q == ARB_LS_ADDR) | (state_q == ARB_LS_READ);
  assign axi_araddr_o = ls_owns_rd ? lsu_araddr_i : ifu_araddr_i;

  // a pending load or store holds back a new fetch, never one already presented
  assign axi_arvalid_o = ((state_q == ARB_IF_ADDR) & ifu_arvalid_i & (if_hold_q | ~lsu_req)) |
                         ((state_q == ARB_LS_ADDR) & lsu_arvalid_i & ~timer_hit);

  assign axi_awvalid_o = (state_q == ARB_LS_WRITE) & lsu_awvalid_i & ~aw_done_q;
  assign axi_wvalid_o  = (state_q == ARB_LS_WRITE) & lsu_wvalid_i & ~w_done_q;

  assign timer_rd_en_o = (state_q == ARB_LS_ADDR) & timer_hit;
  assign rd_is_timer_o = timer_hit;

  assign ifu_rvalid_o = (state_q == ARB_IF_DATA) & axi_rvalid_i;
  assign lsu_rvalid_o = (state_q == ARB_LS_READ) &
                        (timer_hit ? timer_rd_valid_i : axi_rvalid_i);
  assign lsu_wready_o = (state_q == ARB_LS_WRITE) & axi_bvalid_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= ARB_IF_ADDR;
      if_hold_q <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      if_hold_q <= (state_q == ARB_IF_ADDR) & axi_arvalid_o & ~axi_arready_i;

      case (state_q)
        ARB_IF_ADDR:
        begin
          if (axi_arvalid_o)
          begin
            if (axi_arready_i)
              state_q <= ARB_IF_DATA;
          end
          else if (lsu_arvalid_i)
            state_q <= ARB_LS_ADDR; // loads before stores
          else if (lsu_awvalid_i)
            state_q <= ARB_LS_WRITE;
        end

        ARB_IF_DATA:
        begin
          if (axi_rvalid_i)
            state_q <= ARB_IF_ADDR;
        end

        ARB_LS_ADDR:
        begin
          if (timer_hit)
            state_q <= ARB_LS_READ; // timer answers next cycle
          else if (axi_arvalid_o & axi_arready_i)
            state_q <= ARB_LS_READ;
          else if (!lsu_arvalid_i)
            state_q <= ARB_IF_ADDR;
        end

        ARB_LS_READ:
        begin
          if (lsu_rvalid_o)
            state_q <= ARB_IF_ADDR;
        end

        ARB_LS_WRITE:
        begin
          // each channel handshakes once, B ends the store
          if (axi_awvalid_o & axi_awready_i)
            aw_done_q <= 1'b1;
          if (axi_wvalid_o & axi_wready_i)
            w_done_q <= 1'b1;
          if (axi_bvalid_i)
          begin
            state_q   <= ARB_IF_ADDR;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
        end

        default:
          state_q <= ARB_IF_ADDR;
      endcase
    end
  end

endmodule

// ==== src/mem_bus_top.sv ====
`timescale 1ns/1ps
`include "bus_macros.svh"

module mem_bus_top (
  input  logic                   clk,
  input  logic                   rst,

  // fetch port
  input  logic [`ADDR_W-1:0]     ifu_araddr_i,
  input  logic                   ifu_arvalid_i,
  output logic [`DATA_W-1:0]     ifu_rdata_o,
  output logic                   ifu_rvalid_o,

  // load port
  input  logic [`ADDR_W-1:0]     lsu_araddr_i,
  input  logic                   lsu_arvalid_i,
  input  logic [7:0]             lsu_rstrb_i,
  output logic [`DATA_W-1:0]     lsu_rdata_o,
  output logic                   lsu_rvalid_o,

  // store port
  input  logic [`ADDR_W-1:0]     lsu_awaddr_i,
  input  logic                   lsu_awvalid_i,
  input  logic [`DATA_W-1:0]     lsu_wdata_i,
  input  logic [7:0]             lsu_wstrb_i,
  input  logic                   lsu_wvalid_i,
  output logic                   lsu_wready_o,

  // AXI4 master
  output logic                   axi_arvalid_o,
  input  logic                   axi_arready_i,
  output logic [`ADDR_W-1:0]     axi_araddr_o,
  output axi_pkg::axi_size_e     axi_arsize_o,
  input  logic                   axi_rvalid_i,
  output logic                   axi_rready_o,
  input  logic [`AXI_DATA_W-1:0] axi_rdata_i,
  input  axi_pkg::axi_resp_e     axi_rresp_i,
  output logic                   axi_awvalid_o,
  input  logic                   axi_awready_i,
  output logic [`ADDR_W-1:0]     axi_awaddr_o,
  output axi_pkg::axi_size_e     axi_awsize_o,
  output logic                   axi_wvalid_o,
  input  logic                   axi_wready_i,
  output logic [`AXI_DATA_W-1:0] axi_wdata_o,
  output logic [7:0]             axi_wstrb_o,
  input  logic                   axi_bvalid_i,
  output logic                   axi_bready_o,
  input  axi_pkg::axi_resp_e     axi_bresp_i
);

  import axi_pkg::*;

  logic               rd_is_timer;
  logic               timer_rd_en;
  logic               timer_rd_valid;
  logic [`DATA_W-1:0] timer_rd_data;
  logic [`DATA_W-1:0] rd_word;
  logic [7:0]         rd_strb;

  assign axi_rready_o = 1'b1;
  assign axi_bready_o = 1'b1;
  assign axi_awaddr_o = lsu_awaddr_i;

  // fetches always read a full word
  assign rd_strb = lsu_arvalid_i ? lsu_rstrb_i : 8'h0f;

  assign ifu_rdata_o = rd_word;
  assign lsu_rdata_o = rd_is_timer ? timer_rd_data : rd_word;

  bus_arbiter arb_i (
    .clk              (clk),
    .rst              (rst),
    .ifu_arvalid_i    (ifu_arvalid_i),
    .ifu_araddr_i     (ifu_araddr_i),
    .lsu_arvalid_i    (lsu_arvalid_i),
    .lsu_araddr_i     (lsu_araddr_i),
    .lsu_awvalid_i    (lsu_awvalid_i),
    .lsu_wvalid_i     (lsu_wvalid_i),
    .timer_rd_en_o    (timer_rd_en),
    .timer_rd_valid_i (timer_rd_valid),
    .axi_arvalid_o    (axi_arvalid_o),
    .axi_arready_i    (axi_arready_i),
    .axi_araddr_o     (axi_araddr_o),
    .axi_rvalid_i     (axi_rvalid_i),
    .axi_awvalid_o    (axi_awvalid_o),
    .axi_awready_i    (axi_awready_i),
    .axi_wvalid_o     (axi_wvalid_o),
    .axi_wready_i     (axi_wready_i),
    .axi_bvalid_i     (axi_bvalid_i),
    .ifu_rvalid_o     (ifu_rvalid_o),
    .lsu_rvalid_o     (lsu_rvalid_o),
    .lsu_wready_o     (lsu_wready_o),
    .rd_is_timer_o    (rd_is_timer)
  );

  lane_align align_i (
    .rd_addr_i   (axi_araddr_o),
    .rd_strb_i   (rd_strb),
    .wr_addr_i   (lsu_awaddr_i),
    .wr_data_i   (lsu_wdata_i),
    .wr_strb_i   (lsu_wstrb_i),
    .axi_rdata_i (axi_rdata_i),
    .ar_size_o   (axi_arsize_o),
    .aw_size_o   (axi_awsize_o),
    .axi_wdata_o (axi_wdata_o),
    .axi_wstrb_o (axi_wstrb_o),
    .rd_word_o   (rd_word)
  );

  clint clint_i (
    .clk        (clk),
    .rst        (rst),
    .rd_en_i    (timer_rd_en),
    .rd_addr_i  (lsu_araddr_i), // timer reads only come from the lsu
    .rd_data_o  (timer_rd_data),
    .rd_valid_o (timer_rd_valid)
  );

endmodule

// ==== test/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
  input  logic               clk,
  input  logic               rst,
  input  logic               arvalid_i,
  output logic               arready_o,
  input  logic [31:0]        araddr_i,
  output logic               rvalid_o,
  input  logic               rready_i,
  output logic [63:0]        rdata_o,
  output axi_pkg::axi_resp_e rresp_o,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  logic [31:0]        awaddr_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  input  logic [63:0]        wdata_i,
  input  logic [7:0]         wstrb_i,
  output logic               bvalid_o,
  input  logic               bready_i,
  output axi_pkg::axi_resp_e bresp_o
);

  import axi_pkg::*;

  logic [63:0] mem [0:255];
  logic [31:0] rnd;
  integer      seed;
  logic        rd_pend;
  logic [1:0]  rd_wait;
  logic [7:0]  rd_idx;
  logic        aw_got;
  logic        w_got;
  logic [7:0]  wr_idx;
  logic [63:0] wr_data;
  logic [7:0]  wr_strb;
  logic        b_pend;
  logic [1:0]  b_wait;

  initial
  begin
    seed = 82;
  end

  assign rresp_o = RESP_OKAY;
  assign bresp_o = RESP_OKAY;

  task preload(input logic [7:0] idx, input logic [63:0] val);
    mem[idx] = val;
  endtask

  function logic [63:0] peek(input logic [7:0] idx);
    return mem[idx];
  endfunction

  always @(posedge clk)
  begin
    rnd = $random(seed);
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rd_pend   <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_pend    <= 1'b0;
    end
    else
    begin
      if (rvalid_o && rready_i)
        rvalid_o <= 1'b0;
      if (arvalid_i && arready_o)
      begin
        rd_pend <= 1'b1;
        rd_idx  <= araddr_i[10:3];
        rd_wait <= rnd[1:0]; // random read latency
      end
      else if (rd_pend)
      begin
        if (rd_wait == 2'd0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[rd_idx];
          rd_pend  <= 1'b0;
        end
        else
          rd_wait <= rd_wait - 2'd1;
      end
      arready_o <= rnd[2] & ~rd_pend & ~(arvalid_i & arready_o);

      if (awvalid_i && awready_o)
      begin
        aw_got <= 1'b1;
        wr_idx <= awaddr_i[10:3];
      end
      if (wvalid_i && wready_o)
      begin
        w_got   <= 1'b1;
        wr_data <= wdata_i;
        wr_strb <= wstrb_i;
      end
      if (aw_got && w_got)
      begin
        for (int b = 0; b < 8; b++)
        begin
          if (wr_strb[b])
            mem[wr_idx][b*8 +: 8] = wr_data[b*8 +: 8];
        end
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_pend <= 1'b1;
        b_wait <= rnd[4:3];
      end
      else if (b_pend)
      begin
        if (b_wait == 2'd0)
        begin
          bvalid_o <= 1'b1;
          b_pend   <= 1'b0;
        end
        else
          b_wait <= b_wait - 2'd1;
      end
      if (bvalid_o && bready_i)
        bvalid_o <= 1'b0;
      awready_o <= rnd[5] & ~aw_got & ~(awvalid_i & awready_o);
      wready_o  <= rnd[6] & ~w_got & ~(wvalid_i & wready_o);
    end
  end

endmodule

// ==== test/tb_mem_bus.sv ====
`timescale 1ns/1ps
`include "bus_macros.svh"

module tb_mem_bus;

  import axi_pkg::*;
  import lsu_pkg::*;

  localparam int TIMEOUT = 100;

  typedef enum logic [1:0] {OP_FETCH, OP_LOAD, OP_STORE, OP_BOTH} op_e;

  // exp holds the load word, or the merged 64-bit word for stores
  typedef struct packed {
    op_e           op;
    logic [31:0]   addr;
    access_width_e width;
    logic [31:0]   data; // load address for OP_BOTH
    logic [63:0]   exp;
    logic [31:0]   exp2; // fetch word for OP_BOTH
  } row_t;

  logic clk;
  logic rst;
  logic [31:0] ifu_araddr_i;
  logic        ifu_arvalid_i;
  logic [31:0] ifu_rdata_o;
  logic        ifu_rvalid_o;
  logic [31:0] lsu_araddr_i;
  logic        lsu_arvalid_i;
  logic [7:0]  lsu_rstrb_i;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_awaddr_i;
  logic        lsu_awvalid_i;
  logic [31:0] lsu_wdata_i;
  logic [7:0]  lsu_wstrb_i;
  logic        lsu_wvalid_i;
  logic        lsu_wready_o;
  logic        arvalid, arready, rvalid, rready, awvalid, awready;
  logic        wvalid, wready, bvalid, bready;
  logic [31:0] araddr, awaddr;
  logic [63:0] rdata, wdata;
  logic [7:0]  wstrb;
  axi_size_e   arsize, awsize;
  axi_resp_e   rresp, bresp;

  row_t        rows[$];
  logic [63:0] ref_mem [0:255];
  int          errors;
  int          checks;
  logic        ar_seen;
  logic [2:0]  obs_arsize;
  logic [2:0]  obs_awsize;
  logic [7:0]  obs_wstrb;

  // payload history for the stability check
  logic        ar_stall, aw_stall, w_stall;
  logic [31:0] prev_araddr, prev_awaddr;
  logic [2:0]  prev_arsize, prev_awsize;
  logic [63:0] prev_wdata;
  logic [7:0]  prev_wstrb;

  mem_bus_top dut_i (
    .clk (clk), .rst (rst),
    .ifu_araddr_i (ifu_araddr_i), .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_rdata_o (ifu_rdata_o), .ifu_rvalid_o (ifu_rvalid_o),
    .lsu_araddr_i (lsu_araddr_i), .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rstrb_i (lsu_rstrb_i), .lsu_rdata_o (lsu_rdata_o), .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_awaddr_i (lsu_awaddr_i), .lsu_awvalid_i (lsu_awvalid_i),
    .lsu_wdata_i (lsu_wdata_i), .lsu_wstrb_i (lsu_wstrb_i),
    .lsu_wvalid_i (lsu_wvalid_i), .lsu_wready_o (lsu_wready_o),
    .axi_arvalid_o (arvalid), .axi_arready_i (arready), .axi_araddr_o (araddr),
    .axi_arsize_o (arsize), .axi_rvalid_i (rvalid), .axi_rready_o (rready),
    .axi_rdata_i (rdata), .axi_rresp_i (rresp),
    .axi_awvalid_o (awvalid), .axi_awready_i (awready), .axi_awaddr_o (awaddr),
    .axi_awsize_o (awsize), .axi_wvalid_o (wvalid), .axi_wready_i (wready),
    .axi_wdata_o (wdata), .axi_wstrb_o (wstrb),
    .axi_bvalid_i (bvalid), .axi_bready_o (bready), .axi_bresp_i (bresp)
  );

  axi_mem_model mem_i (
    .clk (clk), .rst (rst),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [7:0] strb_for(input access_width_e w);
    case (w)
      WIDTH_H: return 8'h03;
      WIDTH_W: return 8'h0f;
      default: return 8'h01;
    endcase
  endfunction

  // AxSIZE is log2 of the byte count
  function automatic logic [2:0] size_for(input access_width_e w);
    case (w)
      WIDTH_H: return 3'd1;
      WIDTH_W: return 3'd2;
      default: return 3'd0;
    endcase
  endfunction

  function automatic logic [31:0] lane_word(input logic [63:0] w, input logic [31:0] a);
    return a[2] ? w[63:32] : w[31:0];
  endfunction

  function automatic logic [63:0] merge_store(input logic [63:0] old, input logic [31:0] a,
                                              input access_width_e w, input logic [31:0] d);
    logic [63:0] res;
    logic [7:0]  m;
    res = old;
    m = strb_for(w);
    for (int b = 0; b < 4; b++)
    begin
      if (m[b])
        res[(int'(a[2:0]) + b)*8 +: 8] = d[b*8 +: 8];
    end
    return res;
  endfunction

  // both halves depend on the whole byte address
  function automatic logic [63:0] fill_word(input int idx);
    logic [31:0] a;
    a = 32'h8000_0000 + 32'(idx * 8);
    return {(a + 32'd4) * 32'h9e37_79b1, (a * 32'h9e37_79b1) ^ 32'h0f0f_0f0f};
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else
    begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else
    begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not complete within %0d cycles", what, TIMEOUT);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("tests failed");
    $finish;
  endtask

  // protocol monitor on pre-edge values
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (arvalid)
        ar_seen = 1'b1;
      if (ar_stall)
        assert (arvalid && araddr == prev_araddr && arsize == prev_arsize) else
        begin
          errors++;
          $display("read address payload changed while waiting for arready");
        end
      if (aw_stall)
        assert (awvalid && awaddr == prev_awaddr && awsize == prev_awsize) else
        begin
          errors++;
          $display("write address payload changed while waiting for awready");
        end
      if (w_stall)
        assert (wvalid && wdata == prev_wdata && wstrb == prev_wstrb) else
        begin
          errors++;
          $display("write data payload changed while waiting for wready");
        end
      if (arvalid && arready)
        obs_arsize = arsize;
      if (awvalid && awready)
        obs_awsize = awsize;
      if (wvalid && wready)
        obs_wstrb = wstrb;
    end
    ar_stall    = !rst && arvalid && !arready;
    aw_stall    = !rst && awvalid && !awready;
    w_stall     = !rst && wvalid && !wready;
    prev_araddr = araddr;
    prev_arsize = arsize;
    prev_awaddr = awaddr;
    prev_awsize = awsize;
    prev_wdata  = wdata;
    prev_wstrb  = wstrb;
  end

  task automatic run_fetch(input logic [31:0] addr, output logic [31:0] data);
    int cycles;
    cycles = 0;
    data = '0;
    ifu_araddr_i  = addr;
    ifu_arvalid_i = 1'b1;
    do
    begin
      @(negedge clk);
      cycles++;
    end while (!ifu_rvalid_o && cycles < TIMEOUT);
    if (!ifu_rvalid_o)
      report_timeout("fetch");
    else
    begin
      data = ifu_rdata_o;
      @(negedge clk); // request held through the completion edge
      ifu_arvalid_i = 1'b0;
    end
  endtask

  task automatic run_load(input logic [31:0] addr, input access_width_e w,
                          output logic [31:0] data);
    int cycles;
    cycles = 0;
    data = '0;
    lsu_araddr_i  = addr;
    lsu_rstrb_i   = strb_for(w);
    lsu_arvalid_i = 1'b1;
    do
    begin
      @(negedge clk);
      cycles++;
    end while (!lsu_rvalid_o && cycles < TIMEOUT);
    if (!lsu_rvalid_o)
      report_timeout("load");
    else
    begin
      data = lsu_rdata_o;
      @(negedge clk);
      lsu_arvalid_i = 1'b0;
    end
  endtask

  task automatic run_store(input logic [31:0] addr, input access_width_e w,
                           input logic [31:0] d);
    int cycles;
    cycles = 0;
    lsu_awaddr_i  = addr;
    lsu_wdata_i   = d;
    lsu_wstrb_i   = strb_for(w);
    lsu_awvalid_i = 1'b1;
    lsu_wvalid_i  = 1'b1;
    do
    begin
      @(negedge clk);
      cycles++;
    end while (!lsu_wready_o && cycles < TIMEOUT);
    if (!lsu_wready_o)
      report_timeout("store");
    else
    begin
      @(negedge clk);
      lsu_awvalid_i = 1'b0;
      lsu_wvalid_i  = 1'b0;
    end
  endtask

  // raises fetch and load together and records which finishes first
  task automatic run_both(input logic [31:0] faddr, input logic [31:0] laddr,
                          output logic [31:0] fdata, output logic [31:0] ldata,
                          output logic load_first);
    int   cycles;
    logic f_done;
    logic l_done;
    cycles = 0;
    f_done = 1'b0;
    l_done = 1'b0;
    fdata = '0;
    ldata = '0;
    load_first = 1'b0;
    ifu_araddr_i  = faddr;
    lsu_araddr_i  = laddr;
    lsu_rstrb_i   = 8'h0f;
    ifu_arvalid_i = 1'b1;
    lsu_arvalid_i = 1'b1;
    while (!(f_done && l_done) && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      if (l_done)
        lsu_arvalid_i = 1'b0;
      if (f_done)
        ifu_arvalid_i = 1'b0;
      if (!l_done && lsu_rvalid_o)
      begin
        l_done = 1'b1;
        ldata = lsu_rdata_o;
        load_first = !f_done;
      end
      if (!f_done && ifu_rvalid_o)
      begin
        f_done = 1'b1;
        fdata = ifu_rdata_o;
      end
    end
    if (!(f_done && l_done))
      report_timeout("simultaneous fetch and load");
    else
    begin
      @(negedge clk);
      ifu_arvalid_i = 1'b0;
      lsu_arvalid_i = 1'b0;
    end
  endtask

  task automatic add_row(input op_e op, input logic [31:0] addr, input access_width_e w,
                         input logic [31:0] d);
    row_t r;
    r.op = op;
    r.addr = addr;
    r.width = w;
    r.data = d;
    r.exp = '0;
    r.exp2 = '0;
    rows.push_back(r);
  endtask

  initial
  begin
    logic [31:0] got;
    logic [31:0] got2;
    logic [31:0] prev_lo;
    logic        have_lo;
    logic        first;
    logic [7:0]  idx;
    rst = 1'b1;
    ifu_araddr_i = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i = '0;
    lsu_arvalid_i = 1'b0;
    lsu_rstrb_i = '0;
    lsu_awaddr_i = '0;
    lsu_awvalid_i = 1'b0;
    lsu_wdata_i = '0;
    lsu_wstrb_i = '0;
    lsu_wvalid_i = 1'b0;
    errors = 0;
    checks = 0;
    have_lo = 1'b0;
    prev_lo = '0;
    ar_seen = 1'b0;
    obs_arsize = '0;
    obs_awsize = '0;
    obs_wstrb = '0;

    for (int i = 0; i < 256; i++)
    begin
      ref_mem[i] = fill_word(i);
      mem_i.preload(8'(i), fill_word(i));
    end

    add_row(OP_FETCH, 32'h8000_0000, WIDTH_W, '0);
    add_row(OP_FETCH, 32'h8000_0004, WIDTH_W, '0);
    add_row(OP_LOAD,  32'h8000_0030, WIDTH_W, '0);
    add_row(OP_STORE, 32'h8000_0010, WIDTH_B, 32'h0000_0011);
    add_row(OP_STORE, 32'h8000_0011, WIDTH_B, 32'h0000_0022);
    add_row(OP_STORE, 32'h8000_0012, WIDTH_B, 32'h0000_0033);
    add_row(OP_STORE, 32'h8000_0013, WIDTH_B, 32'h0000_0044);
    add_row(OP_STORE, 32'h8000_0014, WIDTH_B, 32'h0000_0055);
    add_row(OP_STORE, 32'h8000_0015, WIDTH_B, 32'h0000_00ee);
    add_row(OP_STORE, 32'h8000_0016, WIDTH_B, 32'ha5a5_a566);
    add_row(OP_STORE, 32'h8000_0017, WIDTH_B, 32'h0000_0077);
    add_row(OP_LOAD,  32'h8000_0010, WIDTH_W, '0);
    add_row(OP_LOAD,  32'h8000_0015, WIDTH_B, '0);
    add_row(OP_STORE, 32'h8000_0018, WIDTH_H, 32'h0000_beef);
    add_row(OP_STORE, 32'h8000_001a, WIDTH_H, 32'h0000_cafe);
    add_row(OP_STORE, 32'h8000_001c, WIDTH_H, 32'h7777_5a5a);
    add_row(OP_STORE, 32'h8000_001e, WIDTH_H, 32'h0000_1234);
    add_row(OP_LOAD,  32'h8000_0018, WIDTH_H, '0);
    add_row(OP_LOAD,  32'h8000_001c, WIDTH_W, '0);
    add_row(OP_STORE, 32'h8000_0020, WIDTH_W, 32'h1357_9bdf);
    add_row(OP_STORE, 32'h8000_0024, WIDTH_W, 32'hdead_0001);
    add_row(OP_LOAD,  32'h8000_0024, WIDTH_W, '0);
    add_row(OP_LOAD,  32'h8000_0020, WIDTH_W, '0);
    add_row(OP_LOAD,  `MTIME_LO_ADDR, WIDTH_W, '0);
    add_row(OP_LOAD,  `MTIME_LO_ADDR, WIDTH_W, '0);
    add_row(OP_LOAD,  `MTIME_HI_ADDR, WIDTH_W, '0);
    add_row(OP_BOTH,  32'h8000_0008, WIDTH_W, 32'h8000_0010);
    add_row(OP_BOTH,  32'h8000_0024, WIDTH_W, 32'h8000_001c);
    add_row(OP_FETCH, 32'h8000_0024, WIDTH_W, '0);

    // expected values from a walk over the reference memory
    for (int i = 0; i < rows.size(); i++)
    begin
      idx = rows[i].addr[10:3];
      case (rows[i].op)
        OP_STORE:
        begin
          ref_mem[idx] = merge_store(ref_mem[idx], rows[i].addr, rows[i].width, rows[i].data);
          rows[i].exp = ref_mem[idx];
        end
        OP_BOTH:
        begin
          rows[i].exp = {32'd0, lane_word(ref_mem[rows[i].data[10:3]], rows[i].data)};
          rows[i].exp2 = lane_word(ref_mem[idx], rows[i].addr);
        end
        default:
          rows[i].exp = {32'd0, lane_word(ref_mem[idx], rows[i].addr)};
      endcase
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    foreach (rows[i])
    begin
      case (rows[i].op)
        OP_FETCH:
        begin
          run_fetch(rows[i].addr, got);
          check_val("ifu_rdata_o", {32'd0, got}, rows[i].exp);
          check_val("axi_arsize_o", {61'd0, obs_arsize}, {61'd0, size_for(WIDTH_W)});
        end
        OP_LOAD:
        begin
          if (rows[i].addr == `MTIME_LO_ADDR || rows[i].addr == `MTIME_HI_ADDR)
          begin
            ar_seen = 1'b0;
            run_load(rows[i].addr, rows[i].width, got);
            check_true(!ar_seen, "timer load put a read on the AXI bus");
            if (rows[i].addr == `MTIME_HI_ADDR)
              check_val("lsu_rdata_o", {32'd0, got}, 64'd0);
            else
            begin
              if (have_lo)
                check_true(got > prev_lo, "mtime low word did not increase");
              prev_lo = got;
              have_lo = 1'b1;
            end
          end
          else
          begin
            run_load(rows[i].addr, rows[i].width, got);
            check_val("lsu_rdata_o", {32'd0, got}, rows[i].exp);
            check_val("axi_arsize_o", {61'd0, obs_arsize},
                      {61'd0, size_for(rows[i].width)});
          end
        end
        OP_STORE:
        begin
          run_store(rows[i].addr, rows[i].width, rows[i].data);
          check_val("axi_awsize_o", {61'd0, obs_awsize}, {61'd0, size_for(rows[i].width)});
          check_val("axi_wstrb_o", {56'd0, obs_wstrb},
                    {56'd0, strb_for(rows[i].width) << rows[i].addr[2:0]});
          check_val("memory word", mem_i.peek(rows[i].addr[10:3]), rows[i].exp);
        end
        default:
        begin
          run_both(rows[i].addr, rows[i].data, got2, got, first);
          check_true(first, "fetch completed before the simultaneous load");
          check_val("lsu_rdata_o", {32'd0, got}, rows[i].exp);
          check_val("ifu_rdata_o", {32'd0, got2}, {32'd0, rows[i].exp2});
        end
      endcase
    end

    @(negedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
src/axi_pkg.sv
src/lsu_pkg.sv
src/clint.sv
src/lane_align.sv
src/bus_arbiter.sv
src/mem_bus_top.sv
test/axi_mem_model.sv
test/tb_mem_bus.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module tb_mem_bus -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
